/* bench/commit_top_tb.sv */
`timescale 1ns/1ns

`include "commit_consts.svh"

module commit_top_tb;
    import commit_pkg::*;

    localparam int LANES        = `RETIRE_WIDTH;
    localparam int DEPTH        = `ROB_DEPTH;
    localparam int TAG_CYCLES   = 12;    // tag wrap test
    localparam int RAND_CYCLES  = 120;   // out of order completion test
    localparam int WAIT_LIMIT   = 40;    // max cycles for a drain, a fill or an event
    localparam int TEST_CYCLES  = 8 + TAG_CYCLES + RAND_CYCLES + 16 + 10 + 7 * WAIT_LIMIT;

    // one in-flight instruction as the model sees it
    typedef struct packed {
        rob_tag_t              tag;
        logic [`REG_IDX_W-1:0] dest;
        logic [`XLEN-1:0]      npc;
        logic                  halt;
        logic                  completed;
        logic [`XLEN-1:0]      value;
        logic                  mispredict;
        logic [`XLEN-1:0]      target;
    } model_entry_t;

    logic                                 clock;
    logic                                 reset;
    logic [LANES-1:0]                     dispatch_valid;
    logic [LANES-1:0][`REG_IDX_W-1:0]     dispatch_dest;
    logic [LANES-1:0][`XLEN-1:0]          dispatch_npc;
    logic [LANES-1:0]                     dispatch_halt;
    rob_count_t                           free_slots;
    rob_tag_t                             dispatch_tag;
    logic [LANES-1:0]                     complete_valid;
    rob_tag_t [LANES-1:0]                 complete_tag;
    logic [LANES-1:0][`XLEN-1:0]          complete_value;
    logic [LANES-1:0]                     complete_mispredict;
    logic [LANES-1:0][`XLEN-1:0]          complete_target;
    logic [LANES-1:0]                     commit_valid;
    logic [LANES-1:0]                     commit_wr_en;
    logic [LANES-1:0][`REG_IDX_W-1:0]     commit_wr_idx;
    logic [LANES-1:0][`XLEN-1:0]          commit_wr_data;
    logic [LANES-1:0][`XLEN-1:0]          commit_npc;
    lane_count_t                          completed_insts;
    error_status_t                        error_status;
    logic                                 squash_flag;
    logic [`XLEN-1:0]                     squash_pc;

    // reference model state
    model_entry_t                         model_q[$];  // in flight, oldest first
    rob_tag_t                             model_tail;
    logic                                 model_halted;
    logic [LANES-1:0]                     exp_valid;
    logic [LANES-1:0]                     exp_wr_en;
    logic [LANES-1:0][`REG_IDX_W-1:0]     exp_idx;
    logic [LANES-1:0][`XLEN-1:0]          exp_data;
    logic [LANES-1:0][`XLEN-1:0]          exp_npc;
    int                                   exp_count;
    logic                                 exp_squash;   // pulse seen this cycle
    logic [`XLEN-1:0]                     exp_squash_pc;
    logic                                 squash_done;  // buffer emptied by a squash
    logic                                 misp_armed;
    rob_tag_t                             misp_tag;     // entry that will mispredict
    int                                   n_dispatched;
    int                                   n_committed;  // lanes seen on commit_valid
    int                                   cycles;
    logic [15:0]                          lfsr;

    commit_top i_dut (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;  // 20 ns period

    // watchdog, 40 ns per test cycle plus margin
    initial begin
        #(TEST_CYCLES * 40 + 1000);
        stop_with_failure("Watchdog expired, the run took too long");
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                        name, actual, expected));
        end
    endtask

    function automatic int find_entry(input rob_tag_t tag);
        int found;
        found = -1;
        for (int i = 0; i < model_q.size(); i++) begin
            if (found < 0 && model_q[i].tag == tag && !model_q[i].completed) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic clear_inputs();
        dispatch_valid      = '0;
        dispatch_dest       = '0;
        dispatch_npc        = '0;
        dispatch_halt       = '0;
        complete_valid      = '0;
        complete_tag        = '0;
        complete_value      = '0;
        complete_mispredict = '0;
        complete_target     = '0;
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // what one rising edge does to the buffer
    task automatic advance_model();
        model_entry_t e;
        int           free_before;
        int           n_req;
        int           n_accept;
        int           idx;
        logic         group_end;
        logic         saw_halt;
        exp_valid = '0;
        exp_wr_en = '0;
        exp_idx   = '0;
        exp_data  = '0;
        exp_npc   = '0;
        exp_count = 0;
        if (exp_squash) begin
            model_q.delete();  // younger work dropped, inputs at this edge too
            model_tail  = '0;
            exp_squash  = 1'b0;
            squash_done = 1'b1;
        end else begin
            free_before = DEPTH - model_q.size();
            group_end   = model_halted;  // frozen once halted
            saw_halt    = 1'b0;
            for (int n = 0; n < LANES; n++) begin
                if (!group_end && model_q.size() > 0 && model_q[0].completed) begin
                    e            = model_q.pop_front();
                    exp_valid[n] = 1'b1;
                    exp_wr_en[n] = (e.dest != '0);  // r0 never written
                    exp_idx[n]   = e.dest;
                    exp_data[n]  = e.value;
                    exp_npc[n]   = e.npc;
                    exp_count++;
                    if (e.mispredict) begin
                        exp_squash    = 1'b1;
                        exp_squash_pc = e.target;
                        group_end     = 1'b1;
                    end
                    if (e.halt) begin
                        saw_halt  = 1'b1;
                        group_end = 1'b1;
                    end
                end else begin
                    group_end = 1'b1;  // run from head broken
                end
            end
            model_halted = model_halted | saw_halt;
            // dispatch, trimmed to the space seen before this edge
            n_req = 0;
            for (int n = 0; n < LANES; n++) begin
                n_req = n_req + int'(dispatch_valid[n]);
            end
            n_accept = (n_req < free_before) ? n_req : free_before;
            for (int n = 0; n < n_accept; n++) begin
                e      = '0;
                e.tag  = model_tail + rob_tag_t'(n);
                e.dest = dispatch_dest[n];
                e.npc  = dispatch_npc[n];
                e.halt = dispatch_halt[n];
                model_q.push_back(e);
            end
            model_tail   = model_tail + rob_tag_t'(n_accept);
            n_dispatched = n_dispatched + n_accept;
            for (int n = 0; n < LANES; n++) begin
                if (complete_valid[n]) begin
                    idx = find_entry(complete_tag[n]);
                    if (idx < 0) begin
                        stop_with_failure("A completion named a tag that is not in flight");
                    end else begin
                        e            = model_q[idx];
                        e.completed  = 1'b1;
                        e.value      = complete_value[n];
                        e.mispredict = complete_mispredict[n];
                        e.target     = complete_target[n];
                        model_q[idx] = e;
                    end
                end
            end
        end
    endtask

    task automatic check_outputs();
        check_value("commit_valid", commit_valid, exp_valid);
        check_value("commit_wr_en", commit_wr_en, exp_wr_en);
        for (int n = 0; n < LANES; n++) begin
            if (exp_valid[n]) begin
                check_value($sformatf("commit_wr_idx[%0d]", n), commit_wr_idx[n], exp_idx[n]);
                check_value($sformatf("commit_wr_data[%0d]", n), commit_wr_data[n], exp_data[n]);
            end
            check_value($sformatf("commit_npc[%0d]", n), commit_npc[n], exp_npc[n]);  // 0 idle
        end
        check_value("completed_insts", completed_insts, exp_count);
        check_value("error_status", error_status, model_halted ? halted : no_error);
        check_value("squash_flag", squash_flag, exp_squash);
        if (exp_squash) begin
            check_value("squash_pc", squash_pc, exp_squash_pc);
        end
        check_value("free_slots", free_slots, DEPTH - model_q.size());
        check_value("dispatch_tag", dispatch_tag, model_tail);
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // one clock, then compare and free the inputs for the next cycle
    task automatic step();
        @(posedge clock);
        advance_model();
        #2;
        for (int n = 0; n < LANES; n++) begin
            n_committed = n_committed + int'(commit_valid[n]);  // as the DUT shows it
        end
        check_outputs();
        clear_inputs();
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        clear_inputs();
        repeat (4) @(posedge clock);
        #2;
        reset        = 1'b0;
        model_q.delete();
        model_tail   = '0;
        model_halted = 1'b0;
        exp_squash   = 1'b0;
        exp_valid    = '0;
        exp_wr_en    = '0;
        exp_npc      = '0;
        exp_count    = 0;
        check_outputs();  // empty buffer, idle commit
    endtask

    task automatic drive_dispatch(input int n_want, input int halt_lane);
        int n;
        n = DEPTH - model_q.size();  // never more than free_slots
        if (n_want < n) n = n_want;
        if (exp_squash) n = 0;       // would be thrown away
        for (int k = 0; k < n; k++) begin
            dispatch_valid[k] = 1'b1;
            dispatch_dest[k]  = rand_bits(`REG_IDX_W);
            dispatch_npc[k]   = rand_bits(`XLEN);
            dispatch_halt[k]  = (k == halt_lane);
        end
    endtask

    // shuffled pick among entries still waiting for a result
    task automatic drive_completions(input int n_want);
        int cand[$];
        int k;
        int idx;
        int lane;
        lane = 0;
        if (!exp_squash) begin
            for (int i = 0; i < model_q.size(); i++) begin
                if (!model_q[i].completed) cand.push_back(i);
            end
        end
        while (lane < n_want && cand.size() > 0) begin
            k   = rand_bits(4) % cand.size();
            idx = cand[k];
            cand.delete(k);
            complete_valid[lane] = 1'b1;
            complete_tag[lane]   = model_q[idx].tag;
            complete_value[lane] = rand_bits(`XLEN);
            if (misp_armed && model_q[idx].tag == misp_tag) begin
                complete_mispredict[lane] = 1'b1;
                complete_target[lane]     = rand_bits(`XLEN);
                misp_armed                = 1'b0;
            end
            lane++;
        end
    endtask

    task automatic drain(input string what);
        cycles = 0;
        while (model_q.size() > 0) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_with_failure($sformatf("Buffer did not drain after %s", what));
            end else begin
                drive_completions(LANES);
                step();
                cycles++;
            end
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        lfsr         = 16'd35;
        reset        = 1'b1;
        misp_armed   = 1'b0;
        squash_done  = 1'b0;
        n_dispatched = 0;
        n_committed  = 0;
        clear_inputs();
        apply_reset();

        // tags in order, wrapping past 15
        check_value("free_slots", free_slots, DEPTH);
        check_value("dispatch_tag", dispatch_tag, 0);
        repeat (TAG_CYCLES) begin
            drive_dispatch(2 + rand_bits(1), -1);
            drive_completions(LANES);
            step();
        end
        drain("tag test");

        // random dispatch, shuffled completion, in-order commit
        n_dispatched = 0;
        n_committed  = 0;
        repeat (RAND_CYCLES) begin
            drive_dispatch(rand_bits(2), -1);
            drive_completions(rand_bits(2));
            step();
        end
        drain("random test");
        check_value("n_committed", n_committed, n_dispatched);
        if (n_committed == 0) begin
            stop_with_failure("Random test committed no instruction");
        end

        // fill all slots, nothing done so nothing leaves
        cycles = 0;
        while (model_q.size() < DEPTH) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_with_failure("Buffer never reached full");
            end else begin
                drive_dispatch(LANES, -1);
                step();
                cycles++;
            end
        end
        check_value("free_slots", free_slots, 0);
        repeat (4) begin
            step();
            check_value("commit_valid", commit_valid, 0);
        end
        drain("full buffer test");

        // mispredict in the middle of the window
        repeat (3) begin
            drive_dispatch(LANES, -1);
            step();
        end
        misp_tag    = model_q[4].tag;
        misp_armed  = 1'b1;
        squash_done = 1'b0;
        cycles      = 0;
        while (!squash_done) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_with_failure("Mispredicted branch never caused a squash");
            end else begin
                drive_dispatch(rand_bits(1), -1);
                drive_completions(1 + rand_bits(2) % 3);
                step();
                cycles++;
            end
        end
        check_value("dispatch_tag", dispatch_tag, 0);  // restart from slot 0
        check_value("free_slots", free_slots, DEPTH);
        drive_dispatch(LANES, -1);
        step();
        drain("squash test");

        // halt on the fourth entry, then frozen
        apply_reset();
        drive_dispatch(LANES, -1);
        step();
        drive_dispatch(LANES, 0);
        step();
        cycles = 0;
        while (!model_halted) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_with_failure("Halt instruction never committed");
            end else begin
                drive_dispatch(rand_bits(1), -1);
                drive_completions(1 + rand_bits(2) % 3);
                step();
                cycles++;
            end
        end
        repeat (10) begin
            drive_dispatch(1, -1);   // still accepted while halted
            drive_completions(2);
            step();
            check_value("commit_valid", commit_valid, 0);
            check_value("error_status", error_status, halted);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

/* commit_top.f */
+incdir+common
common/commit_pkg.sv
rob/rob_control.sv
rob/rob_slot_array.sv
src/retire_format.sv
src/commit_top.sv
bench/commit_top_tb.sv

/* common/commit_consts.svh */
`ifndef COMMIT_CONSTS_SVH
`define COMMIT_CONSTS_SVH

//////////////////////////////
// machine width
//////////////////////////////

// lanes per cycle for dispatch, completion and retire
`define RETIRE_WIDTH 3

//////////////////////////////
// reorder buffer
//////////////////////////////

// slot count, keep a power of two so tags wrap for free
`define ROB_DEPTH 16

//////////////////////////////
// datapath
//////////////////////////////

`define REG_IDX_W 5   // arch reg index, r0 reads as zero
`define XLEN 32       // data and pc width

`endif

/* common/commit_pkg.sv */
`include "commit_consts.svh"

package commit_pkg;

    // slot index into the rob, wraps modulo depth
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

    // occupancy or free count, needs one more bit than a tag
    typedef logic [$clog2(`ROB_DEPTH):0] rob_count_t;

    // 0..3 instructions in one group
    typedef logic [1:0] lane_count_t;

    //////////////////////////////
    // slot payloads
    //////////////////////////////

    // written at dispatch, 38 bits
    typedef struct packed {
        logic [`REG_IDX_W-1:0] dest;   // destination reg
        logic [`XLEN-1:0]      npc;    // pc of the next instruction
        logic                  halt;   // halt instruction
    } rob_info_t;

    // written at completion, 65 bits
    typedef struct packed {
        logic [`XLEN-1:0] value;       // result for the dest reg
        logic             mispredict;  // branch went the other way
        logic [`XLEN-1:0] target;      // restart pc on mispredict
    } rob_result_t;

    //////////////////////////////
    // status
    //////////////////////////////

    typedef enum logic {
        no_error = 1'b0,
        halted   = 1'b1
    } error_status_t;

endpackage

/* rob/rob_control.sv */
`timescale 1ns/1ns

`include "commit_consts.svh"

module rob_control (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [`RETIRE_WIDTH-1:0]                 dispatch_valid,
    input  logic [`RETIRE_WIDTH-1:0]                 complete_valid,
    input  commit_pkg::rob_tag_t [`RETIRE_WIDTH-1:0] complete_tag,
    input  logic [`RETIRE_WIDTH-1:0]                 head_info_halt,         // per head slot
    input  logic [`RETIRE_WIDTH-1:0]                 head_result_mispredict, // per head slot
    input  logic                                     halted,  // sticky, from retire_format
    input  logic                                     squash,  // registered, from retire_format
    output commit_pkg::rob_count_t                   free_slots,
    output commit_pkg::rob_tag_t                     dispatch_tag,
    output logic [`RETIRE_WIDTH-1:0]                 dispatch_we,
    output commit_pkg::rob_tag_t                     head_tag,
    output logic [`RETIRE_WIDTH-1:0]                 retire_valid
);
    import commit_pkg::*;

    rob_tag_t                        head;       // oldest slot
    rob_tag_t                        tail;       // next slot to hand out
    rob_count_t                      count;      // occupied slots
    logic [`ROB_DEPTH-1:0]           done;       // result written, one bit per slot

    rob_tag_t [`RETIRE_WIDTH-1:0]    head_slot;  // head + lane
    logic [`RETIRE_WIDTH-1:0]        slot_done;  // occupied and finished
    logic [`RETIRE_WIDTH-1:0]        stop;       // group must end after this lane
    rob_count_t                      n_dispatch;
    rob_count_t                      n_retire;

    assign free_slots   = rob_count_t'(`ROB_DEPTH) - count;  // 0 when full
    assign dispatch_tag = tail;
    assign head_tag     = head;                               // read base for both arrays

    //////////////////////////////
    // dispatch trim
    //////////////////////////////

    // lanes are contiguous from 0, so lane n fits if more than n slots are free
    always_comb begin
        for (int n = 0; n < `RETIRE_WIDTH; n++) begin
            dispatch_we[n] = dispatch_valid[n] && (free_slots > rob_count_t'(n)) && !squash;
        end
    end

    //////////////////////////////
    // retire selection
    //////////////////////////////

    always_comb begin
        for (int n = 0; n < `RETIRE_WIDTH; n++) begin
            head_slot[n] = head + rob_tag_t'(n);  // wraps
            // count check guards against stale done bits past the tail
            slot_done[n] = done[head_slot[n]] && (count > rob_count_t'(n));
            stop[n]      = head_info_halt[n] || head_result_mispredict[n];
        end
    end

    // longest run of done slots from the head
    // a mispredict or halt is the last lane taken
    always_comb begin
        retire_valid[0] = slot_done[0] && !halted && !squash;  // frozen once halted
        for (int n = 1; n < `RETIRE_WIDTH; n++) begin
            retire_valid[n] = retire_valid[n-1] && !stop[n-1] && slot_done[n];
        end
    end

    // lane counts for the pointer updates
    always_comb begin
        n_dispatch = '0;
        n_retire   = '0;
        for (int n = 0; n < `RETIRE_WIDTH; n++) begin
            n_dispatch = n_dispatch + rob_count_t'(dispatch_we[n]);
            n_retire   = n_retire + rob_count_t'(retire_valid[n]);
        end
    end

    //////////////////////////////
    // state update
    //////////////////////////////

    // squash arrives one cycle after the mispredict retired
    // everything younger is thrown away and tags restart at 0
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            head  <= head + rob_tag_t'(n_retire);
            tail  <= tail + rob_tag_t'(n_dispatch);
            count <= count + n_dispatch - n_retire;
            for (int n = 0; n < `RETIRE_WIDTH; n++) begin
                if (retire_valid[n]) begin
                    done[head_slot[n]] <= 1'b0;  // slot free for reuse
                end
                // completion never targets a slot retiring this cycle
                if (complete_valid[n]) begin
                    done[complete_tag[n]] <= 1'b1;
                end
            end
        end
    end

endmodule

/* rob/rob_slot_array.sv */
`timescale 1ns/1ns

`include "commit_consts.svh"

// slot storage, one instance per payload kind
module rob_slot_array #(
    parameter type payload_t = logic [7:0]
) (
    input  logic                                     clock,
    input  logic [`RETIRE_WIDTH-1:0]                 we,
    input  commit_pkg::rob_tag_t [`RETIRE_WIDTH-1:0] waddr,
    input  payload_t [`RETIRE_WIDTH-1:0]             wdata,
    input  commit_pkg::rob_tag_t                     raddr_base,  // usually the head
    output payload_t [`RETIRE_WIDTH-1:0]             rdata
);
    import commit_pkg::*;

    payload_t                     slots [`ROB_DEPTH];  // validity kept by rob_control
    rob_tag_t [`RETIRE_WIDTH-1:0] raddr;

    //////////////////////////////
    // write ports
    //////////////////////////////

    // addresses within a cycle are distinct, no port priority needed
    always_ff @(posedge clock) begin
        for (int n = 0; n < `RETIRE_WIDTH; n++) begin
            if (we[n]) begin
                slots[waddr[n]] <= wdata[n];
            end
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // three consecutive slots from the base, async read
    always_comb begin
        for (int n = 0; n < `RETIRE_WIDTH; n++) begin
            raddr[n] = raddr_base + rob_tag_t'(n);  // modulo depth
            rdata[n] = slots[raddr[n]];
        end
    end

endmodule

/* src/commit_top.sv */
`timescale 1ns/1ns

`include "commit_consts.svh"

module commit_top (
    input  logic                                     clock,
    input  logic                                     reset,
    // dispatch side
    input  logic [`RETIRE_WIDTH-1:0]                 dispatch_valid,
    input  logic [`RETIRE_WIDTH-1:0][`REG_IDX_W-1:0] dispatch_dest,
    input  logic [`RETIRE_WIDTH-1:0][`XLEN-1:0]      dispatch_npc,
    input  logic [`RETIRE_WIDTH-1:0]                 dispatch_halt,
    output commit_pkg::rob_count_t                   free_slots,
    output commit_pkg::rob_tag_t                     dispatch_tag,   // tag of lane 0
    // completion side
    input  logic [`RETIRE_WIDTH-1:0]                 complete_valid,
    input  commit_pkg::rob_tag_t [`RETIRE_WIDTH-1:0] complete_tag,
    input  logic [`RETIRE_WIDTH-1:0][`XLEN-1:0]      complete_value,
    input  logic [`RETIRE_WIDTH-1:0]                 complete_mispredict,
    input  logic [`RETIRE_WIDTH-1:0][`XLEN-1:0]      complete_target,
    // commit side
    output logic [`RETIRE_WIDTH-1:0]                 commit_valid,
    output logic [`RETIRE_WIDTH-1:0]                 commit_wr_en,
    output logic [`RETIRE_WIDTH-1:0][`REG_IDX_W-1:0] commit_wr_idx,
    output logic [`RETIRE_WIDTH-1:0][`XLEN-1:0]      commit_wr_data,
    output logic [`RETIRE_WIDTH-1:0][`XLEN-1:0]      commit_npc,
    output commit_pkg::lane_count_t                  completed_insts,
    output commit_pkg::error_status_t                error_status,
    output logic                                     squash_flag,
    output logic [`XLEN-1:0]                         squash_pc
);
    import commit_pkg::*;

    logic [`RETIRE_WIDTH-1:0]        dispatch_we;
    rob_tag_t [`RETIRE_WIDTH-1:0]    dispatch_addr;
    rob_info_t [`RETIRE_WIDTH-1:0]   dispatch_info;
    rob_result_t [`RETIRE_WIDTH-1:0] complete_result;
    rob_tag_t                        head_tag;
    rob_info_t [`RETIRE_WIDTH-1:0]   head_info;
    rob_result_t [`RETIRE_WIDTH-1:0] head_result;
    logic [`RETIRE_WIDTH-1:0]        head_halt;
    logic [`RETIRE_WIDTH-1:0]        head_mispredict;
    logic [`RETIRE_WIDTH-1:0]        retire_valid;

    // pack lanes into slot payloads and pull flags back out at the head
    for (genvar n = 0; n < `RETIRE_WIDTH; n++) begin : g_lane
        assign dispatch_addr[n]   = dispatch_tag + rob_tag_t'(n);
        assign dispatch_info[n]   = '{dest: dispatch_dest[n], npc: dispatch_npc[n],
                                      halt: dispatch_halt[n]};
        assign complete_result[n] = '{value: complete_value[n],
                                      mispredict: complete_mispredict[n],
                                      target: complete_target[n]};
        assign head_halt[n]       = head_info[n].halt;
        assign head_mispredict[n] = head_result[n].mispredict;
    end

    //////////////////////////////
    // control
    //////////////////////////////

    rob_control i_rob_control (
        .clock                  (clock),
        .reset                  (reset),
        .dispatch_valid         (dispatch_valid),
        .complete_valid         (complete_valid),
        .complete_tag           (complete_tag),
        .head_info_halt         (head_halt),
        .head_result_mispredict (head_mispredict),
        .halted                 (error_status == halted),
        .squash                 (squash_flag),       // fed back from commit stage
        .free_slots             (free_slots),
        .dispatch_tag           (dispatch_tag),
        .dispatch_we            (dispatch_we),
        .head_tag               (head_tag),
        .retire_valid           (retire_valid)
    );

    //////////////////////////////
    // storage
    //////////////////////////////

    rob_slot_array #(.payload_t(rob_info_t)) i_info_array (  // filled at dispatch
        .clock      (clock),
        .we         (dispatch_we),
        .waddr      (dispatch_addr),
        .wdata      (dispatch_info),
        .raddr_base (head_tag),
        .rdata      (head_info)
    );

    rob_slot_array #(.payload_t(rob_result_t)) i_result_array (  // filled at completion
        .clock      (clock),
        .we         (complete_valid),
        .waddr      (complete_tag),
        .wdata      (complete_result),
        .raddr_base (head_tag),
        .rdata      (head_result)
    );

    //////////////////////////////
    // commit
    //////////////////////////////

    retire_format i_retire_format (
        .clock           (clock),
        .reset           (reset),
        .retire_valid    (retire_valid),
        .head_info       (head_info),
        .head_result     (head_result),
        .commit_valid    (commit_valid),
        .commit_wr_en    (commit_wr_en),
        .commit_wr_idx   (commit_wr_idx),
        .commit_wr_data  (commit_wr_data),
        .commit_npc      (commit_npc),
        .completed_insts (completed_insts),
        .error_status    (error_status),
        .squash_flag     (squash_flag),
        .squash_pc       (squash_pc)
    );

endmodule

/* src/retire_format.sv */
`timescale 1ns/1ns

`include "commit_consts.svh"

module retire_format (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic [`RETIRE_WIDTH-1:0]                    retire_valid,
    input  commit_pkg::rob_info_t [`RETIRE_WIDTH-1:0]   head_info,
    input  commit_pkg::rob_result_t [`RETIRE_WIDTH-1:0] head_result,
    output logic [`RETIRE_WIDTH-1:0]                    commit_valid,
    output logic [`RETIRE_WIDTH-1:0]                    commit_wr_en,
    output logic [`RETIRE_WIDTH-1:0][`REG_IDX_W-1:0]    commit_wr_idx,
    output logic [`RETIRE_WIDTH-1:0][`XLEN-1:0]         commit_wr_data,
    output logic [`RETIRE_WIDTH-1:0][`XLEN-1:0]         commit_npc,
    output commit_pkg::lane_count_t                     completed_insts,
    output commit_pkg::error_status_t                   error_status,
    output logic                                        squash_flag,
    output logic [`XLEN-1:0]                            squash_pc
);
    import commit_pkg::*;

    lane_count_t      retire_count;
    logic             retire_mispredict;  // at most one lane, always the last
    logic             retire_halt;
    logic [`XLEN-1:0] retire_target;

    // summarize the group leaving the head this cycle
    always_comb begin
        retire_count      = '0;
        retire_mispredict = 1'b0;
        retire_halt       = 1'b0;
        retire_target     = '0;
        for (int n = 0; n < `RETIRE_WIDTH; n++) begin
            if (retire_valid[n]) begin
                retire_count = retire_count + lane_count_t'(1);
                if (head_result[n].mispredict) begin
                    retire_mispredict = 1'b1;
                    retire_target     = head_result[n].target;
                end
                if (head_info[n].halt) begin
                    retire_halt = 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // commit stage, control
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid    <= '0;
            commit_wr_en    <= '0;
            completed_insts <= '0;
            squash_flag     <= 1'b0;
            error_status    <= no_error;
        end else begin
            commit_valid    <= retire_valid;
            completed_insts <= retire_count;
            squash_flag     <= retire_mispredict;  // one cycle, rob_control clears on it
            for (int n = 0; n < `RETIRE_WIDTH; n++) begin
                commit_wr_en[n] <= retire_valid[n] && (head_info[n].dest != '0);  // skip r0
            end
            if (retire_halt) begin
                error_status <= halted;  // held until reset
            end
        end
    end

    //////////////////////////////
    // commit stage, payload
    //////////////////////////////

    always_ff @(posedge clock) begin
        for (int n = 0; n < `RETIRE_WIDTH; n++) begin
            commit_wr_idx[n]  <= head_info[n].dest;
            commit_wr_data[n] <= head_result[n].value;
            commit_npc[n]     <= retire_valid[n] ? head_info[n].npc : '0;  // zero on idle lanes
        end
        if (retire_mispredict) begin
            squash_pc <= retire_target;  // restart point for fetch
        end
    end

endmodule
